/* src/axil_pkg.sv */
// Shared types for a single 32-bit AXI-Lite bus with no bursts and the protection field held at zero
package axil_pkg;

	////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////

	localparam int xlen        = 32;
	localparam int strb_w      = xlen / 8;          // Byte lanes
	localparam int addr_lsb    = $clog2(strb_w);    // Byte offset bits inside a word
	localparam int mem_words   = 64;
	localparam int mem_idx_w   = $clog2(mem_words); // Word index bits
	localparam int mem_timeout = 16;                // Cycles from address to response

	////////////////////////////////////////
	// Bus encodings
	////////////////////////////////////////

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;
	localparam logic [2:0] basic_prot  = 3'b000;    // Unprivileged, secure, data access

	typedef logic [xlen-1:0] data_t;

	// Processor side request, held until done
	typedef struct packed {
		logic [xlen-1:0]   addr;
		data_t             wdata;
		logic              rd;
		logic              wr;
		logic [strb_w-1:0] be;                      // Write byte enables
	} mem_req_t;

	// Everything the master drives
	typedef struct packed {
		logic [xlen-1:0]   awaddr;
		logic [2:0]        awprot;
		logic              awvalid;
		data_t             wdata;
		logic [strb_w-1:0] wstrb;
		logic              wvalid;
		logic              bready;
		logic [xlen-1:0]   araddr;
		logic [2:0]        arprot;
		logic              arvalid;
		logic              rready;
	} axil_m2s_t;

	// Everything the slave drives
	typedef struct packed {
		logic              awready;
		logic              wready;
		logic [1:0]        bresp;
		logic              bvalid;
		logic              arready;
		data_t             rdata;
		logic [1:0]        rresp;
		logic              rvalid;
	} axil_s2m_t;

endpackage : axil_pkg

/* src/mem_sys_axil.sv */
// Runs one processor request at a time over AXI-Lite and expects req to stay stable until done
`timescale 1ns/1ps

module mem_sys_axil (
	input  logic                m_axil_clk,
	input  logic                rst_n,

	input  axil_pkg::mem_req_t  req,
	input  logic                req_valid,
	output axil_pkg::data_t     rdata,
	output logic                done,
	output logic                err,

	output axil_pkg::axil_m2s_t bus_m2s,
	input  axil_pkg::axil_s2m_t bus_s2m
);

	import axil_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_r_addr,
		st_r_data,
		st_w_addr,
		st_w_data,
		st_w_resp
	} state_t;

	state_t state, nxt_state;

	logic w_acc, nxt_w_acc;       // Write data taken before its address
	logic rd_req, wr_req;
	logic rd_phase, wr_phase;
	logic ar_v, aw_v, w_v;
	logic ar_fire, r_fire, aw_fire, w_fire, b_fire;
	logic addr_ok, data_ok;

	assign rd_req = req_valid & req.rd;
	assign wr_req = req_valid & req.wr & ~req.rd; // Read wins if both flags are set

	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			w_acc <= 1'b0;
		end else begin
			state <= nxt_state;
			w_acc <= nxt_w_acc;
		end
	end

	////////////////////////////////////////
	// Channel valids and handshakes
	////////////////////////////////////////

	always_comb begin
		ar_v = 1'b0;
		aw_v = 1'b0;
		w_v  = 1'b0;
		case (state)
			st_idle: begin
				ar_v = rd_req;
				aw_v = wr_req;
				w_v  = wr_req;
			end
			st_r_addr: ar_v = 1'b1;
			st_w_addr: begin
				aw_v = 1'b1;
				w_v  = ~w_acc;        // Data may already be in
			end
			st_w_data: w_v = 1'b1;
			default: ;
		endcase
	end

	// Which transaction the current cycle belongs to
	assign rd_phase = (state == st_idle && rd_req) || state == st_r_addr || state == st_r_data;
	assign wr_phase = (state == st_idle && wr_req) || state == st_w_addr ||
		state == st_w_data || state == st_w_resp;

	assign ar_fire = ar_v & bus_s2m.arready;
	assign aw_fire = aw_v & bus_s2m.awready;
	assign w_fire  = w_v & bus_s2m.wready;
	assign r_fire  = rd_phase & bus_s2m.rvalid & bus_m2s.rready;
	assign b_fire  = wr_phase & bus_s2m.bvalid & bus_m2s.bready;

	// Steps finished by now, counting the ones firing this cycle
	assign addr_ok = aw_fire || state == st_w_data || state == st_w_resp;
	assign data_ok = w_fire || w_acc || state == st_w_resp;

	always_comb begin
		bus_m2s.awaddr  = req.addr;
		bus_m2s.awprot  = basic_prot;
		bus_m2s.awvalid = aw_v;
		bus_m2s.wdata   = req.wdata;
		bus_m2s.wstrb   = req.be;
		bus_m2s.wvalid  = w_v;
		bus_m2s.bready  = 1'b1;   // Responses never stalled
		bus_m2s.araddr  = req.addr;
		bus_m2s.arprot  = basic_prot;
		bus_m2s.arvalid = ar_v;
		bus_m2s.rready  = 1'b1;
	end

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		nxt_state = state;
		if (rd_phase) begin
			if (r_fire)
				nxt_state = st_idle;
			else if (ar_fire || state == st_r_data)
				nxt_state = st_r_data;
			else
				nxt_state = st_r_addr;
		end else if (wr_phase) begin
			if (b_fire)
				nxt_state = st_idle;  // Response closes the write
			else if (addr_ok && data_ok)
				nxt_state = st_w_resp;
			else if (addr_ok)
				nxt_state = st_w_data;
			else
				nxt_state = st_w_addr;
		end else begin
			nxt_state = st_idle;
		end
	end

	// Early data is remembered only while the address is still out
	assign nxt_w_acc = (nxt_state == st_w_addr) & data_ok;

	////////////////////////////////////////
	// Completion
	////////////////////////////////////////

	assign done  = r_fire | b_fire;
	assign rdata = r_fire ? bus_s2m.rdata : '0;
	assign err   = (r_fire && bus_s2m.rresp != resp_okay) ||
		(b_fire && bus_s2m.bresp != resp_okay);

endmodule : mem_sys_axil

/* src/axil_sram_slave.sv */
// Word memory cleared by reset and only one write and one read may be open at a time
`timescale 1ns/1ps

module axil_sram_slave (
	input  logic                m_axil_clk,
	input  logic                rst_n,

	input  axil_pkg::axil_m2s_t bus_m2s,
	output axil_pkg::axil_s2m_t bus_s2m
);

	import axil_pkg::*;

	data_t mem [mem_words];

	logic                 wr_rdy;     // Shared by awready and wready
	logic                 bvalid;
	logic [1:0]           bresp;
	logic                 rvalid;
	logic [1:0]           rresp;
	data_t                rdata;
	logic                 arready;

	logic                 wr_go, rd_go;
	logic                 wr_hit, rd_hit;
	logic [mem_idx_w-1:0] wr_idx, rd_idx;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign wr_idx = bus_m2s.awaddr[addr_lsb +: mem_idx_w];
	assign rd_idx = bus_m2s.araddr[addr_lsb +: mem_idx_w];

	// Full word index against the depth
	assign wr_hit = bus_m2s.awaddr[xlen-1:addr_lsb] < (xlen-addr_lsb)'(mem_words);
	assign rd_hit = bus_m2s.araddr[xlen-1:addr_lsb] < (xlen-addr_lsb)'(mem_words);

	////////////////////////////////////////
	// Write channels
	////////////////////////////////////////

	// Address and data always land together
	assign wr_go = wr_rdy & bus_m2s.awvalid & bus_m2s.wvalid;

	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_rdy <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			wr_rdy <= ~wr_rdy & bus_m2s.awvalid & bus_m2s.wvalid & ~bvalid;
			if (wr_go)
				bvalid <= 1'b1;
			else if (bus_m2s.bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge m_axil_clk) begin
		if (wr_go)
			bresp <= wr_hit ? resp_okay : resp_slverr;
	end

	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < mem_words; i++)
				mem[i] <= '0;
		end else if (wr_go && wr_hit) begin
			for (int b = 0; b < strb_w; b++) begin
				if (bus_m2s.wstrb[b])
					mem[wr_idx][8*b +: 8] <= bus_m2s.wdata[8*b +: 8];
			end
		end
	end

	////////////////////////////////////////
	// Read channels
	////////////////////////////////////////

	assign arready = ~rvalid;           // Free while no data is waiting
	assign rd_go   = bus_m2s.arvalid & arready;

	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n)
			rvalid <= 1'b0;
		else if (rd_go)
			rvalid <= 1'b1;
		else if (bus_m2s.rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge m_axil_clk) begin
		if (rd_go) begin
			rdata <= rd_hit ? mem[rd_idx] : '0;  // Zero outside the memory
			rresp <= rd_hit ? resp_okay : resp_slverr;
		end
	end

	always_comb begin
		bus_s2m.awready = wr_rdy;
		bus_s2m.wready  = wr_rdy;
		bus_s2m.bresp   = bresp;
		bus_s2m.bvalid  = bvalid;
		bus_s2m.arready = arready;
		bus_s2m.rdata   = rdata;
		bus_s2m.rresp   = rresp;
		bus_s2m.rvalid  = rvalid;
	end

endmodule : axil_sram_slave

/* src/mem_sys_top.sv */
// Single clock domain where the processor holds req until done and issues one request at a time
`timescale 1ns/1ps

module mem_sys_top (
	input  logic               m_axil_clk,
	input  logic               rst_n,

	input  axil_pkg::mem_req_t req,
	input  logic               req_valid,
	output axil_pkg::data_t    rdata,
	output logic               done,
	output logic               err
);

	import axil_pkg::*;

	axil_m2s_t bus_m2s;   // Master to memory
	axil_s2m_t bus_s2m;   // Memory back to master

	////////////////////////////////////////
	// Bus master
	////////////////////////////////////////

	mem_sys_axil master_i (
		.m_axil_clk (m_axil_clk),
		.rst_n      (rst_n),
		.req        (req),
		.req_valid  (req_valid),
		.rdata      (rdata),
		.done       (done),
		.err        (err),
		.bus_m2s    (bus_m2s),
		.bus_s2m    (bus_s2m)
	);

	////////////////////////////////////////
	// On-chip memory
	////////////////////////////////////////

	axil_sram_slave sram_i (
		.m_axil_clk (m_axil_clk),
		.rst_n      (rst_n),
		.bus_m2s    (bus_m2s),
		.bus_s2m    (bus_s2m)
	);

endmodule : mem_sys_top

/* bench/mem_sys_properties.sv */
// Bound into the AXI-Lite master and assumes it holds bready and rready high
`timescale 1ns/1ps

module mem_sys_properties (
	input logic                m_axil_clk,
	input logic                rst_n,
	input axil_pkg::axil_m2s_t bus_m2s,
	input axil_pkg::axil_s2m_t bus_s2m,
	input logic                done
);

	import axil_pkg::*;

	logic ar_hs, r_hs, aw_hs, b_hs;
	logic rd_open, wr_open;      // Address accepted, response still out
	int   rd_wait, wr_wait;

	assign ar_hs = bus_m2s.arvalid & bus_s2m.arready;
	assign r_hs  = bus_s2m.rvalid & bus_m2s.rready;
	assign aw_hs = bus_m2s.awvalid & bus_s2m.awready;
	assign b_hs  = bus_s2m.bvalid & bus_m2s.bready;

	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_open <= 1'b0;
			rd_wait <= 0;
			wr_open <= 1'b0;
			wr_wait <= 0;
		end else begin
			if (ar_hs) begin
				rd_open <= 1'b1;
				rd_wait <= 0;
			end else if (r_hs)
				rd_open <= 1'b0;
			else if (rd_open)
				rd_wait <= rd_wait + 1;
			if (aw_hs) begin
				wr_open <= 1'b1;
				wr_wait <= 0;
			end else if (b_hs)
				wr_open <= 1'b0;
			else if (wr_open)
				wr_wait <= wr_wait + 1;
		end
	end

	////////////////////////////////////////
	// Handshake rules
	////////////////////////////////////////

	aw_hold: assert property (@(posedge m_axil_clk) disable iff (!rst_n)
		bus_m2s.awvalid && !bus_s2m.awready |=> bus_m2s.awvalid)
		else $error("awvalid dropped before awready");
	w_hold: assert property (@(posedge m_axil_clk) disable iff (!rst_n)
		bus_m2s.wvalid && !bus_s2m.wready |=> bus_m2s.wvalid)
		else $error("wvalid dropped before wready");
	ar_hold: assert property (@(posedge m_axil_clk) disable iff (!rst_n)
		bus_m2s.arvalid && !bus_s2m.arready |=> bus_m2s.arvalid)
		else $error("arvalid dropped before arready");
	done_pulse: assert property (@(posedge m_axil_clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done high for two cycles");
	rd_bound: assert property (@(posedge m_axil_clk) disable iff (!rst_n)
		rd_open |-> rd_wait < mem_timeout)
		else $error("read data late after its address");
	wr_bound: assert property (@(posedge m_axil_clk) disable iff (!rst_n)
		wr_open |-> wr_wait < mem_timeout)
		else $error("write response late after its address");

endmodule : mem_sys_properties

bind mem_sys_axil mem_sys_properties props_i (
	.m_axil_clk (m_axil_clk),
	.rst_n      (rst_n),
	.bus_m2s    (bus_m2s),
	.bus_s2m    (bus_s2m),
	.done       (done)
);

/* bench/mem_sys_tb.sv */
// Reads requests from bench/mem_sys_input.txt so the run must start in the project root
`timescale 1ns/1ps

module mem_sys_tb;

	import axil_pkg::*;

	logic      m_axil_clk;
	logic      rst_n;
	mem_req_t  req;
	logic      req_valid;
	data_t     rdata;
	logic      done;
	logic      err;

	int        n_req;
	int        done_count;

	mem_sys_top dut_i (
		.m_axil_clk (m_axil_clk),
		.rst_n      (rst_n),
		.req        (req),
		.req_valid  (req_valid),
		.rdata      (rdata),
		.done       (done),
		.err        (err)
	);

	initial begin
		m_axil_clk = 1'b0;
		forever #4 m_axil_clk = ~m_axil_clk;   // 8 ns period
	end

	// Every completion pulse, to compare against the request count
	always @(negedge m_axil_clk) begin
		if (rst_n && done)
			done_count++;
	end

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge m_axil_clk);
			#1 req_valid = 1'b0;
		end
	endtask

	// One request held until done, then its response checked
	task automatic run_request(input logic is_wr, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] be, input logic [31:0] exp_rdata,
		input logic exp_err);
		int   waited;
		logic got_done;
		@(posedge m_axil_clk);
		#1;
		req.addr  = addr;
		req.wdata = wdata;
		req.rd    = ~is_wr;
		req.wr    = is_wr;
		req.be    = be;
		req_valid = 1'b1;
		waited    = 0;
		got_done  = 1'b0;
		while (!got_done && waited < mem_timeout) begin
			@(negedge m_axil_clk);   // Outputs settled mid cycle
			if (done)
				got_done = 1'b1;
			else
				waited++;
		end
		if (!got_done) begin
			$display("Request %0d at address 0x%08h never finished", n_req, addr);
			$display("STATUS: FAIL");
			$fatal(1, "Timed out waiting for done");
		end
		check_value("err", {31'b0, err}, {31'b0, exp_err});
		if (!is_wr)
			check_value("rdata", rdata, exp_rdata);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int          fd;
		int          cnt;
		int          gap;
		string       line;
		logic [7:0]  op;
		logic [31:0] addr, wdata, exp_rdata;
		logic [3:0]  be;
		logic        exp_err;

		rst_n      = 1'b0;
		req        = '0;
		req_valid  = 1'b0;
		n_req      = 0;
		done_count = 0;
		void'($urandom(17));
		repeat (2) @(posedge m_axil_clk);
		#1 rst_n = 1'b1;

		fd = $fopen("bench/mem_sys_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file bench/mem_sys_input.txt");
			$display("STATUS: FAIL");
			$fatal(1, "No stimulus file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;                    // Blank or comment line
			cnt = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, be, exp_rdata, exp_err);
			if (cnt != 6 || (op != "R" && op != "W")) begin
				$display("Stimulus line could not be read: %s", line);
				$display("STATUS: FAIL");
				$fatal(1, "Bad stimulus line");
			end
			gap = $urandom % 4;
			idle_cycles(gap);
			n_req++;
			run_request(op == "W", addr, wdata, be, exp_rdata, exp_err);
		end
		$fclose(fd);

		idle_cycles(3);
		check_value("done_count", 32'(done_count), 32'(n_req));
		$display("STATUS: PASS");
		$finish;
	end

endmodule : mem_sys_tb

/* bench/mem_sys_input.txt */
# op addr wdata be expected_rdata expected_err, all hex, op is R or W
# Word index is addr[31:2] and index 64 or above is out of range
R 00000010 00000000 0 00000000 0
W 00000020 a1b2c3d4 f 00000000 0
R 00000020 00000000 0 a1b2c3d4 0
W 00000020 000000ee 1 00000000 0
R 00000020 00000000 0 a1b2c3ee 0
W 00000020 55660000 c 00000000 0
R 00000020 00000000 0 5566c3ee 0
W 00000024 12345678 f 00000000 0
W 00000028 0000ab00 2 00000000 0
R 00000024 00000000 0 12345678 0
R 00000028 00000000 0 0000ab00 0
W 00000100 deadbeef f 00000000 1
R 00000100 00000000 0 00000000 1
W 000000fc cafef00d f 00000000 0
R 000000fc 00000000 0 cafef00d 0
R 000000f8 00000000 0 00000000 0
W 00000400 01020304 f 00000000 1
R 00000400 00000000 0 00000000 1
R 00000020 00000000 0 5566c3ee 0
W 00000030 11223344 6 00000000 0
R 00000030 00000000 0 00223300 0
R 00000034 00000000 0 00000000 0
R 0000002c 00000000 0 00000000 0

/* vlog.f */
src/axil_pkg.sv
src/mem_sys_axil.sv
src/axil_sram_slave.sv
src/mem_sys_top.sv
bench/mem_sys_properties.sv
bench/mem_sys_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the memory port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f vlog.f \
	--top-module mem_sys_tb \
	-o mem_sys_sim

./obj_dir/mem_sys_sim
